// ==== run.sh ====
#!/bin/sh
# Builds and runs tb_ioclr_top with Verilator and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert -Wno-fatal --top-module tb_ioclr_top -f tb.f -o sim_ioclr \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_ioclr > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src/ioclr_status.sv ====
// ##############################
// Timeout status and interrupt
// Sticky flag, saturating counter, irq
// ##############################

`timescale 1ns/100ps

module ioclr_status
  import wb_regs_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ioclrtmout,
  input  logic                 sticky_clr,
  input  logic                 irq_en_we,
  input  logic                 irq_en_d,
  output logic                 sticky,
  output logic                 irq_en,
  output logic [TMO_CNT_W-1:0] tmo_cnt,
  output logic                 irq
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky  <= 1'b0;
      tmo_cnt <= '0;
      irq_en  <= 1'b0;
      irq     <= 1'b0;
    end else begin
      // Set beats clear in the same cycle
      if (ioclrtmout) begin
        sticky <= 1'b1;
      end else if (sticky_clr) begin
        sticky <= 1'b0;
      end

      // Saturating timeout count
      if (ioclrtmout && (tmo_cnt != '1)) begin
        tmo_cnt <= tmo_cnt + 1'b1;
      end

      if (irq_en_we) begin
        irq_en <= irq_en_d;
      end

      // One cycle behind sticky and the enable
      irq <= sticky & irq_en;
    end
  end

  a_cnt_mono: assert property (@(posedge clk) disable iff (!rst_n)
    tmo_cnt >= $past(tmo_cnt))
    else $error("tmo_cnt decreased");

endmodule

// ==== src/ioclr_timeout_fsm.sv ====
// ##############################
// I/O-clear timeout state machine
// Five timed steps with a prescaler, then IOCLR
// ##############################

`timescale 1ns/100ps

module ioclr_timeout_fsm
  import ioclr_types_pkg::*;
#(
  // Clocks spent in each TCN step
  parameter int PRESCALE = 4
)
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    foocr_we,
  input  logic    ioclrinst,
  input  logic    fooc2_qual,
  output tstate_t tstate,
  output logic    ioclrtmout
);

  localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

  tstate_t       ntstate;
  logic [PW-1:0] pcnt;
  logic          counting;
  logic          cancel;
  logic          step_done;

  assign counting  = tstate inside {TCN1, TCN2, TCN3, TCN4, TCN5};
  assign cancel    = ioclrinst | fooc2_qual;
  assign step_done = (pcnt == PW'(PRESCALE - 1));

  // Next state
  always_comb begin
    ntstate = tstate;
    case (tstate)
      TIDLE: ntstate = foocr_we ? TCN1 : TIDLE;
      TCN1, TCN2, TCN3, TCN4, TCN5: begin
        if (cancel) begin
          ntstate = TIDLE;
        end else if (step_done) begin
          // TCN5 steps on to IOCLR the same way
          ntstate = tstate_t'(tstate + 3'd1);
        end
      end
      IOCLR:   ntstate = TIDLE;
      // TUNU1 recovers to idle
      default: ntstate = TIDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tstate <= TIDLE;
    end else begin
      tstate <= ntstate;
    end
  end

  // Step prescaler
  // Held at zero outside the count so that entering TCN1 reloads it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcnt <= '0;
    end else if (counting && !cancel && !step_done) begin
      pcnt <= pcnt + 1'b1;
    end else begin
      pcnt <= '0;
    end
  end

  // Timeout pulse for the single IOCLR cycle
  assign ioclrtmout = (tstate == IOCLR);

  a_ioclr_exit: assert property (@(posedge clk) disable iff (!rst_n)
    (tstate == IOCLR) |-> ioclrtmout ##1 (tstate == TIDLE))
    else $error("IOCLR without pulse or not followed by TIDLE");

  // Pulse only ever comes out of a full count
  a_tmout_src: assert property (@(posedge clk) disable iff (!rst_n)
    ioclrtmout |-> (tstate == IOCLR) && ($past(tstate) == TCN5))
    else $error("ioclrtmout outside IOCLR after TCN5");

  a_cancel: assert property (@(posedge clk) disable iff (!rst_n)
    (counting && cancel) |=> (tstate == TIDLE))
    else $error("cancel in TCN state did not return to TIDLE");

  a_no_x: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(tstate))
    else $error("tstate unknown");

endmodule

// ==== src/ioclr_top.sv ====
// ##############################
// I/O-clear timeout controller top
// Register slave, timeout FSM, status block
// ##############################

`timescale 1ns/100ps

module ioclr_top
  import wb_regs_pkg::*;
  import ioclr_types_pkg::*;
#(
  parameter int PRESCALE = 4
)
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [WB_AW-1:0] wb_adr,
  input  logic [WB_DW-1:0] wb_dat_w,
  input  logic             fooc2_qual,
  output logic [WB_DW-1:0] wb_dat_r,
  output logic             wb_ack,
  output logic             ioclrtmout,
  output logic             irq
);

  tstate_t              tstate;
  logic                 foocr_we;
  logic                 ioclrinst;
  logic                 sticky_clr;
  logic                 irq_en_we;
  logic                 irq_en_d;
  logic                 sticky;
  logic                 irq_en;
  logic [TMO_CNT_W-1:0] tmo_cnt;

  wb_ctrl_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .tstate     (tstate),
    .sticky     (sticky),
    .irq_en     (irq_en),
    .tmo_cnt    (tmo_cnt),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .foocr_we   (foocr_we),
    .ioclrinst  (ioclrinst),
    .sticky_clr (sticky_clr),
    .irq_en_we  (irq_en_we),
    .irq_en_d   (irq_en_d)
  );

  ioclr_timeout_fsm #(
    .PRESCALE (PRESCALE)
  ) u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .foocr_we   (foocr_we),
    .ioclrinst  (ioclrinst),
    .fooc2_qual (fooc2_qual),
    .tstate     (tstate),
    .ioclrtmout (ioclrtmout)
  );

  ioclr_status u_status (
    .clk        (clk),
    .rst_n      (rst_n),
    .ioclrtmout (ioclrtmout),
    .sticky_clr (sticky_clr),
    .irq_en_we  (irq_en_we),
    .irq_en_d   (irq_en_d),
    .sticky     (sticky),
    .irq_en     (irq_en),
    .tmo_cnt    (tmo_cnt),
    .irq        (irq)
  );

endmodule

// ==== src/ioclr_types_pkg.sv ====
// ##############################
// I/O-clear timeout types
// State encoding and state-field width of the timeout machine
// ##############################

package ioclr_types_pkg;

  // Width of the state field, also used for status readback
  localparam int TSTATE_W = 3;

  // Timeout machine states
  // TCN1 to TCN5 are the timed steps, IOCLR is the one-cycle timeout state
  typedef enum logic [TSTATE_W-1:0] {
    TIDLE = 3'd0,
    TCN1  = 3'd1,
    TCN2  = 3'd2,
    TCN3  = 3'd3,
    TCN4  = 3'd4,
    TCN5  = 3'd5,
    IOCLR = 3'd6,
    // Unused code, only ever left toward idle
    TUNU1 = 3'd7
  } tstate_t;

endpackage

// ==== src/wb_ctrl_regs.sv ====
// ##############################
// Wishbone classic register slave
// Turns writes into command pulses, muxes read data
// ##############################

`timescale 1ns/100ps

module wb_ctrl_regs
  import wb_regs_pkg::*;
  import ioclr_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [WB_AW-1:0]     wb_adr,
  input  logic [WB_DW-1:0]     wb_dat_w,
  input  tstate_t              tstate,
  input  logic                 sticky,
  input  logic                 irq_en,
  input  logic [TMO_CNT_W-1:0] tmo_cnt,
  output logic [WB_DW-1:0]     wb_dat_r,
  output logic                 wb_ack,
  output logic                 foocr_we,
  output logic                 ioclrinst,
  output logic                 sticky_clr,
  output logic                 irq_en_we,
  output logic                 irq_en_d
);

  logic             req;
  logic             wr;
  logic             rd;
  logic [WB_DW-1:0] status_word;
  logic [WB_DW-1:0] rd_mux;

  // New request only when ack is not already high
  assign req = wb_cyc & wb_stb & ~wb_ack;
  assign wr  = req & wb_we;
  assign rd  = req & ~wb_we;

  always_comb begin
    status_word                                    = '0;
    status_word[STATUS_STICKY]                     = sticky;
    status_word[STATUS_BUSY]                       = (tstate != TIDLE);
    status_word[STATUS_STATE_LSB +: TSTATE_W]      = tstate;
  end

  // Unused addresses and write-only CTRL read as zero
  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      ADDR_STATUS:  rd_mux = status_word;
      ADDR_IRQ_EN:  rd_mux[0] = irq_en;
      ADDR_TMO_CNT: rd_mux[TMO_CNT_W-1:0] = tmo_cnt;
      default:      rd_mux = '0;
    endcase
  end

  // Ack and command pulses share the acknowledging edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack     <= 1'b0;
      wb_dat_r   <= '0;
      foocr_we   <= 1'b0;
      ioclrinst  <= 1'b0;
      sticky_clr <= 1'b0;
      irq_en_we  <= 1'b0;
    end else begin
      wb_ack     <= req;
      foocr_we   <= wr & (wb_adr == ADDR_CTRL) & wb_dat_w[CTRL_START];
      ioclrinst  <= wr & (wb_adr == ADDR_CTRL) & wb_dat_w[CTRL_CLEAR];
      sticky_clr <= wr & (wb_adr == ADDR_STATUS) & wb_dat_w[STATUS_STICKY];
      irq_en_we  <= wr & (wb_adr == ADDR_IRQ_EN);
      if (rd) begin
        wb_dat_r <= rd_mux;
      end
    end
  end

  // Enable value, only looked at together with irq_en_we
  always_ff @(posedge clk) begin
    if (wr) begin
      irq_en_d <= wb_dat_w[0];
    end
  end

  // Classic handshake gives single-cycle acks only
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high for two cycles");

endmodule

// ==== src/wb_regs_pkg.sv ====
// ##############################
// Register map of the I/O-clear timeout controller
// Bus widths, word addresses and bit positions
// ##############################

package wb_regs_pkg;

  // Bus widths
  localparam int WB_AW = 4;
  localparam int WB_DW = 32;

  // Word addresses
  localparam logic [WB_AW-1:0] ADDR_CTRL    = 4'd0;
  localparam logic [WB_AW-1:0] ADDR_STATUS  = 4'd1;
  localparam logic [WB_AW-1:0] ADDR_IRQ_EN  = 4'd2;
  localparam logic [WB_AW-1:0] ADDR_TMO_CNT = 4'd3;

  // CTRL bits, write only, each bit gives a command pulse
  localparam int CTRL_START = 0;
  localparam int CTRL_CLEAR = 1;

  // STATUS bits
  localparam int STATUS_STICKY    = 0;
  localparam int STATUS_BUSY      = 1;
  // State field occupies bits 4:2
  localparam int STATUS_STATE_LSB = 2;

  // Timeout counter width, saturates at all ones
  localparam int TMO_CNT_W = 8;

endpackage

// ==== tb.f ====
src/ioclr_types_pkg.sv
src/wb_regs_pkg.sv
src/wb_ctrl_regs.sv
src/ioclr_timeout_fsm.sv
src/ioclr_status.sv
src/ioclr_top.sv
test/ioclr_checker.sv
test/tb_ioclr_top.sv

// ==== test/ioclr_checker.sv ====
// ##############################
// Checker for the I/O-clear timeout controller
// Cycle model built from port activity, compares DUT outputs
// ##############################

`timescale 1ns/100ps

module ioclr_checker
  import wb_regs_pkg::*;
  import ioclr_types_pkg::*;
#(
  parameter int PRESCALE = 4
)
(
  input logic             clk,
  input logic             rst_n,
  input logic             wb_cyc,
  input logic             wb_stb,
  input logic             wb_we,
  input logic [WB_AW-1:0] wb_adr,
  input logic [WB_DW-1:0] wb_dat_w,
  input logic             fooc2_qual,
  input logic [WB_DW-1:0] wb_dat_r,
  input logic             wb_ack,
  input logic             ioclrtmout,
  input logic             irq
);

  int test_err  = 0;
  int err_total = 0;
  int n_pass    = 0;
  int n_fail    = 0;

  // Model of the DUT registers as they stand after the last rising edge
  logic [TSTATE_W-1:0]  m_state;
  int                   m_pcnt;
  logic [TMO_CNT_W-1:0] m_cnt;
  logic [WB_DW-1:0]     m_rdata;
  logic                 m_sticky;
  logic                 m_ien;
  logic                 m_irq;
  logic                 m_ack;
  logic                 m_rd;
  logic                 m_start;
  logic                 m_clr;
  logic                 m_sclr;
  logic                 m_ienwe;
  logic                 m_iend;

  task automatic compare(string sig, logic [WB_DW-1:0] got, logic [WB_DW-1:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", sig, got, exp, $time);
      test_err++;
      err_total++;
    end
  endtask

  task automatic end_test(string name);
    if (test_err == 0) begin
      $display("%-12s ok", name);
      n_pass++;
    end else begin
      $display("%-12s failed with %0d errors", name, test_err);
      n_fail++;
    end
    test_err = 0;
  endtask

  task automatic summary();
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             n_pass + n_fail, n_pass, n_fail, err_total);
  endtask

  // Outputs are compared at the falling edge
  // Then the model takes the inputs that the next rising edge will see
  always @(negedge clk) begin : model
    logic req;
    if (!rst_n) begin
      m_state  = TIDLE;
      m_pcnt   = 0;
      m_cnt    = '0;
      m_rdata  = '0;
      m_sticky = 1'b0;
      m_ien    = 1'b0;
      m_irq    = 1'b0;
      m_ack    = 1'b0;
      m_rd     = 1'b0;
      m_start  = 1'b0;
      m_clr    = 1'b0;
      m_sclr   = 1'b0;
      m_ienwe  = 1'b0;
      m_iend   = 1'b0;
    end else begin
      compare("wb_ack", WB_DW'(wb_ack), WB_DW'(m_ack));
      compare("ioclrtmout", WB_DW'(ioclrtmout), WB_DW'(m_state == IOCLR));
      compare("irq", WB_DW'(irq), WB_DW'(m_irq));
      if (m_ack && m_rd) begin
        compare("wb_dat_r", wb_dat_r, m_rdata);
      end
      req = wb_cyc & wb_stb & ~m_ack;
      if (req && !wb_we) begin
        m_rdata = '0;
        case (wb_adr)
          ADDR_STATUS: begin
            m_rdata[STATUS_STICKY]                = m_sticky;
            m_rdata[STATUS_BUSY]                  = (m_state != TIDLE);
            m_rdata[STATUS_STATE_LSB +: TSTATE_W] = m_state;
          end
          ADDR_IRQ_EN:  m_rdata[0] = m_ien;
          ADDR_TMO_CNT: m_rdata[TMO_CNT_W-1:0] = m_cnt;
          default:      m_rdata = '0;
        endcase
      end
      // irq lags sticky and the enable by one edge
      m_irq = m_sticky & m_ien;
      if (m_state == IOCLR) begin
        m_sticky = 1'b1;
        if (m_cnt != '1) begin
          m_cnt = m_cnt + 1'b1;
        end
      end else if (m_sclr) begin
        m_sticky = 1'b0;
      end
      if (m_ienwe) begin
        m_ien = m_iend;
      end
      if (m_state == TIDLE) begin
        m_state = m_start ? TCN1 : TIDLE;
        m_pcnt  = 0;
      end else if (m_state <= TCN5) begin
        if (m_clr || fooc2_qual) begin
          m_state = TIDLE;
          m_pcnt  = 0;
        end else if (m_pcnt == PRESCALE - 1) begin
          // IOCLR follows TCN5 in the encoding
          m_state = m_state + 1'b1;
          m_pcnt  = 0;
        end else begin
          m_pcnt++;
        end
      end else begin
        m_state = TIDLE;
      end
      m_rd    = req & ~wb_we;
      m_start = req & wb_we & (wb_adr == ADDR_CTRL) & wb_dat_w[CTRL_START];
      m_clr   = req & wb_we & (wb_adr == ADDR_CTRL) & wb_dat_w[CTRL_CLEAR];
      m_sclr  = req & wb_we & (wb_adr == ADDR_STATUS) & wb_dat_w[STATUS_STICKY];
      m_ienwe = req & wb_we & (wb_adr == ADDR_IRQ_EN);
      if (req && wb_we) begin
        m_iend = wb_dat_w[0];
      end
      m_ack   = req;
    end
  end

endmodule

// ==== test/tb_ioclr_top.sv ====
// ##############################
// Testbench for the I/O-clear timeout controller
// Table-driven Wishbone stimulus, ioclr_checker compares
// ##############################

`timescale 1ns/100ps

module tb_ioclr_top
  import wb_regs_pkg::*;
();

  localparam int PRESCALE   = 4;
  localparam int ROW_CYCLES = 40;
  localparam int RST_CYCLES = 16;

  typedef enum int {OP_RD, OP_WR, OP_START, OP_CLR, OP_QUAL, OP_BUSY, OP_IRQ} op_t;

  // dat holds write data, the cancel step or the number of status reads
  typedef struct packed {
    op_t              op;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
    logic [WB_DW-1:0] exp;
  } row_t;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic             fooc2_qual;
  logic [WB_DW-1:0] wb_dat_r;
  logic             wb_ack;
  logic             ioclrtmout;
  logic             irq;
  string            row_name[$];
  row_t             rows[$];
  int               cycles = 0;
  int               limit  = 0;

  ioclr_top #(.PRESCALE(PRESCALE)) DUT (.*);

  ioclr_checker #(.PRESCALE(PRESCALE)) chk (.*);

  task automatic add_row(string name, op_t op, logic [WB_AW-1:0] adr,
                         logic [WB_DW-1:0] dat, logic [WB_DW-1:0] exp);
    row_t r;
    r.op  = op;
    r.adr = adr;
    r.dat = dat;
    r.exp = exp;
    row_name.push_back(name);
    rows.push_back(r);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_gap();
    repeat ($urandom % 4) next_cycle();
  endtask

  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    do begin
      next_cycle();
    end while (!wb_ack);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(logic [WB_AW-1:0] adr, logic [WB_DW-1:0] dat);
    logic [WB_DW-1:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  // Status block needs two more edges after the pulse
  task automatic wait_pulse();
    while (!ioclrtmout) next_cycle();
    repeat (3) next_cycle();
  endtask

  task automatic cancel_count(op_t op, int steps);
    bus_write(ADDR_CTRL, 32'd1 << CTRL_START);
    idle_gap();
    repeat (steps * PRESCALE) next_cycle();
    // Both cancel kinds reach the FSM on the second edge from here
    if (op == OP_CLR) begin
      bus_write(ADDR_CTRL, 32'd1 << CTRL_CLEAR);
    end else begin
      next_cycle();
      fooc2_qual = 1'b1;
      next_cycle();
      fooc2_qual = 1'b0;
    end
    repeat (3) next_cycle();
  endtask

  task automatic busy_count(int reads);
    logic [WB_DW-1:0] v;
    bus_write(ADDR_CTRL, 32'd1 << CTRL_START);
    repeat (reads) begin
      idle_gap();
      bus_read(ADDR_STATUS, v);
      chk.compare("STATUS busy", WB_DW'(v[STATUS_BUSY]), 32'd1);
    end
    // Second start lands mid-count
    bus_write(ADDR_CTRL, 32'd1 << CTRL_START);
    wait_pulse();
  endtask

  task automatic run_row(row_t r);
    logic [WB_DW-1:0] v;
    case (r.op)
      OP_RD: begin
        bus_read(r.adr, v);
        chk.compare("wb_dat_r", v, r.exp);
      end
      OP_WR: bus_write(r.adr, r.dat);
      OP_START: begin
        bus_write(ADDR_CTRL, 32'd1 << CTRL_START);
        wait_pulse();
      end
      OP_CLR, OP_QUAL: cancel_count(r.op, r.dat);
      OP_BUSY: busy_count(r.dat);
      default: begin
        repeat (3) next_cycle();
        chk.compare("irq", WB_DW'(irq), r.exp);
      end
    endcase
  endtask

  task automatic build_table();
    add_row("rst_status",  OP_RD,    ADDR_STATUS,  0, 0);
    add_row("rst_cnt",     OP_RD,    ADDR_TMO_CNT, 0, 0);
    add_row("rst_irq",     OP_IRQ,   ADDR_CTRL,    0, 0);
    add_row("start_tmo",   OP_START, ADDR_CTRL,    0, 0);
    add_row("tmo_status",  OP_RD,    ADDR_STATUS,  0, 1);
    add_row("tmo_cnt",     OP_RD,    ADDR_TMO_CNT, 0, 1);
    add_row("sticky_clr",  OP_WR,    ADDR_STATUS,  1, 0);
    add_row("clr_tcn1",    OP_CLR,   ADDR_CTRL,    0, 0);
    add_row("qual_tcn2",   OP_QUAL,  ADDR_CTRL,    1, 0);
    add_row("clr_tcn3",    OP_CLR,   ADDR_CTRL,    2, 0);
    add_row("qual_tcn4",   OP_QUAL,  ADDR_CTRL,    3, 0);
    add_row("clr_tcn5",    OP_CLR,   ADDR_CTRL,    4, 0);
    add_row("qual_tcn5",   OP_QUAL,  ADDR_CTRL,    4, 0);
    add_row("cncl_status", OP_RD,    ADDR_STATUS,  0, 0);
    add_row("cncl_cnt",    OP_RD,    ADDR_TMO_CNT, 0, 1);
    add_row("busy_start",  OP_BUSY,  ADDR_CTRL,    3, 0);
    add_row("busy_cnt",    OP_RD,    ADDR_TMO_CNT, 0, 2);
    add_row("sticky_clr2", OP_WR,    ADDR_STATUS,  1, 0);
    add_row("irq_en_set",  OP_WR,    ADDR_IRQ_EN,  1, 0);
    add_row("irq_en_rd",   OP_RD,    ADDR_IRQ_EN,  0, 1);
    add_row("irq_idle",    OP_IRQ,   ADDR_CTRL,    0, 0);
    add_row("irq_tmo",     OP_START, ADDR_CTRL,    0, 0);
    add_row("irq_high",    OP_IRQ,   ADDR_CTRL,    0, 1);
    add_row("irq_clr",     OP_WR,    ADDR_STATUS,  1, 0);
    add_row("irq_low",     OP_IRQ,   ADDR_CTRL,    0, 0);
    add_row("irq_en_clr",  OP_WR,    ADDR_IRQ_EN,  0, 0);
    add_row("noirq_tmo",   OP_START, ADDR_CTRL,    0, 0);
    add_row("noirq",       OP_IRQ,   ADDR_CTRL,    0, 0);
    add_row("final_cnt",   OP_RD,    ADDR_TMO_CNT, 0, 4);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit from the table length
  initial begin
    while (limit == 0 || cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h6216d317));
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    fooc2_qual = 1'b0;
    build_table();
    limit = rows.size() * ROW_CYCLES + RST_CYCLES;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (rows[i]) begin
      idle_gap();
      run_row(rows[i]);
      chk.end_test(row_name[i]);
    end
    chk.summary();
    if (chk.err_total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
